/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_hog_grad
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
FAIL_MSG   := test failed
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/band_line_buffer.sv */
`timescale 1ns/1ps

module band_line_buffer
	import hog_pkg::*;
#(
	parameter int FRAME_TILES_X = 53
) (
	input  logic                 clk,
	input  col_idx_t             col,
	input  logic [LINE_BITS-1:0] wr_rows,
	output logic [LINE_BITS-1:0] rd_rows
);

	// address bits actually needed for this frame width
	localparam int AW = (FRAME_TILES_X > 1) ? $clog2(FRAME_TILES_X) : 1;

	logic [LINE_BITS-1:0] mem [FRAME_TILES_X];
	logic [AW-1:0]        idx;

	assign idx = col[AW-1:0];

	////////////////////////////////////////
	// one entry per tile column
	////////////////////////////////////////

	// read sees the previous band, the write lands at the edge
	assign rd_rows = mem[idx];

	always_ff @(posedge clk) begin
		mem[idx] <= wr_rows;
	end

	// tile counter from outside must stay inside the frame width
	a_col_in_frame: assert property (@(posedge clk) int'(col) < FRAME_TILES_X)
		else $error("tile column %0d outside frame of %0d tiles", col, FRAME_TILES_X);

endmodule

/* rtl/gradient_stage.sv */
`timescale 1ns/1ps

module gradient_stage
	import hog_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  win_t      win,
	input  logic      win_valid,
	output grad_vec_t gx,
	output grad_vec_t gy,
	output logic      grad_valid
);

	grad_vec_t gx_d;
	grad_vec_t gy_d;

	// pixel at window row r, column c
	function automatic pix_t pix_at(win_t w, int r, int c);
		return w[(r * WIN_W + c) * PIX_W +: PIX_W];
	endfunction

	// signed difference of two unsigned pixels
	function automatic grad_t diff(pix_t a, pix_t b);
		return grad_t'({1'b0, a}) - grad_t'({1'b0, b});
	endfunction

	////////////////////////////////////////
	// central differences
	////////////////////////////////////////

	// output (r, c) sits at window (r+1, c+1), one up and one left of the tile
	always_comb begin
		for (int r = 0; r < TILE_H; r++) begin
			for (int c = 0; c < TILE_W; c++) begin
				// right minus left
				gx_d[(r * TILE_W + c) * GRAD_W +: GRAD_W] =
					diff(pix_at(win, r + 1, c + 2), pix_at(win, r + 1, c));
				// upper minus lower
				gy_d[(r * TILE_W + c) * GRAD_W +: GRAD_W] =
					diff(pix_at(win, r, c + 1), pix_at(win, r + 2, c + 1));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gx         <= '0;
			gy         <= '0;
			grad_valid <= 1'b0;
		end else begin
			gx         <= gx_d;
			gy         <= gy_d;
			grad_valid <= win_valid;
		end
	end

endmodule

/* rtl/hog_grad_top.sv */
`timescale 1ns/1ps

module hog_grad_top
	import hog_pkg::*;
#(
	parameter int FRAME_TILES_X = 53,
	parameter int FRAME_TILES_Y = 160
) (
	input  logic       clk,
	input  logic       rst_n,
	input  row_idx_t   tile_row,
	input  col_idx_t   tile_col,
	input  block_t     block0,
	input  block_t     block1,
	input  block_t     block2,
	input  block_t     block3,
	output mag_block_t hog_out0,
	output mag_block_t hog_out1,
	output mag_block_t hog_out2,
	output mag_block_t hog_out3,
	output logic       valid
);

	win_t      win;
	logic      win_valid;
	grad_vec_t gx;
	grad_vec_t gy;
	logic      grad_valid;

	////////////////////////////////////////
	// tile in, 5x14 window out
	////////////////////////////////////////
	window_assembler #(
		.FRAME_TILES_X(FRAME_TILES_X)
	) u_win (
		.clk      (clk),
		.rst_n    (rst_n),
		.tile_row (tile_row),
		.tile_col (tile_col),
		.block0   (block0),
		.block1   (block1),
		.block2   (block2),
		.block3   (block3),
		.win      (win),
		.win_valid(win_valid)
	);

	// one cycle
	gradient_stage u_grad (
		.clk       (clk),
		.rst_n     (rst_n),
		.win       (win),
		.win_valid (win_valid),
		.gx        (gx),
		.gy        (gy),
		.grad_valid(grad_valid)
	);

	// two cycles, squares then sums
	magnitude_stage u_mag (
		.clk       (clk),
		.rst_n     (rst_n),
		.gx        (gx),
		.gy        (gy),
		.grad_valid(grad_valid),
		.hog_out0  (hog_out0),
		.hog_out1  (hog_out1),
		.hog_out2  (hog_out2),
		.hog_out3  (hog_out3),
		.valid     (valid)
	);

	// band counter from outside must stay inside the frame height
	a_row_in_frame: assert property (
		@(posedge clk) disable iff (!rst_n) int'(tile_row) < FRAME_TILES_Y)
		else $error("tile row %0d outside frame of %0d bands", tile_row, FRAME_TILES_Y);

endmodule

/* rtl/hog_pkg.sv */
package hog_pkg;

	// pixel and tile geometry
	localparam int PIX_W    = 8;
	localparam int TILE_H   = 3;
	localparam int TILE_W   = 12;
	localparam int BLK_S    = 3;
	localparam int BLK_N    = BLK_S * BLK_S;
	localparam int TILE_BLK = TILE_W / BLK_S;

	// neighbourhood: two extra rows above, two extra columns left
	localparam int WIN_H = TILE_H + 2;
	localparam int WIN_W = TILE_W + 2;

	// one line buffer entry holds two full window rows
	localparam int LINE_BITS = 2 * WIN_W * PIX_W;

	// difference needs a sign bit, sum of two squares one carry bit
	localparam int GRAD_W = PIX_W + 1;
	localparam int MAG_W  = 2 * PIX_W + 1;

	typedef logic [PIX_W-1:0]                    pix_t;
	typedef logic [BLK_N*PIX_W-1:0]              block_t;
	typedef logic signed [GRAD_W-1:0]            grad_t;
	typedef logic [MAG_W-1:0]                    mag_t;
	typedef logic [BLK_N*MAG_W-1:0]              mag_block_t;
	typedef logic [WIN_H*WIN_W*PIX_W-1:0]        win_t;
	typedef logic [TILE_H*TILE_W*GRAD_W-1:0]     grad_vec_t;
	typedef logic [7:0]                          row_idx_t;
	typedef logic [5:0]                          col_idx_t;

endpackage

/* rtl/magnitude_stage.sv */
`timescale 1ns/1ps

module magnitude_stage
	import hog_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  grad_vec_t  gx,
	input  grad_vec_t  gy,
	input  logic       grad_valid,
	output mag_block_t hog_out0,
	output mag_block_t hog_out1,
	output mag_block_t hog_out2,
	output mag_block_t hog_out3,
	output logic       valid
);

	localparam int NPIX    = TILE_H * TILE_W;
	localparam int MAG_MAX = 2 * ((1 << PIX_W) - 1) * ((1 << PIX_W) - 1);

	logic [2*PIX_W-1:0] sq_x [NPIX];
	logic [2*PIX_W-1:0] sq_y [NPIX];
	logic               sq_valid;
	mag_block_t         mag_d [TILE_BLK];
	mag_block_t         mag_q [TILE_BLK];
	logic               mag_over;

	// |g| <= 255, so the square fits in 16 bits
	function automatic logic [2*PIX_W-1:0] square(grad_t g);
		logic signed [2*GRAD_W-1:0] ge;
		logic signed [2*GRAD_W-1:0] p;
		ge = (2*GRAD_W)'(g);
		p = ge * ge;
		return p[2*PIX_W-1:0];
	endfunction

	// full width square of any 9-bit difference
	function automatic int full_square(grad_t g);
		return int'(g) * int'(g);
	endfunction

	////////////////////////////////////////
	// stage 1 squares
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NPIX; i++) begin
				sq_x[i] <= '0;
				sq_y[i] <= '0;
			end
			sq_valid <= 1'b0;
		end else begin
			for (int i = 0; i < NPIX; i++) begin
				sq_x[i] <= square(gx[i * GRAD_W +: GRAD_W]);
				sq_y[i] <= square(gy[i * GRAD_W +: GRAD_W]);
			end
			sq_valid <= grad_valid;
		end
	end

	////////////////////////////////////////
	// stage 2 sums regrouped into blocks
	////////////////////////////////////////
	always_comb begin
		for (int b = 0; b < TILE_BLK; b++)
			mag_d[b] = '0;
		for (int r = 0; r < TILE_H; r++) begin
			for (int c = 0; c < TILE_W; c++) begin
				// block order with top-left at index 8
				mag_d[c / BLK_S][((BLK_S - 1 - r) * BLK_S + BLK_S - 1 - c % BLK_S) * MAG_W
					+: MAG_W] = mag_t'(sq_x[r * TILE_W + c]) + mag_t'(sq_y[r * TILE_W + c]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int b = 0; b < TILE_BLK; b++)
				mag_q[b] <= '0;
			valid <= 1'b0;
		end else begin
			for (int b = 0; b < TILE_BLK; b++)
				mag_q[b] <= mag_d[b];
			valid <= sq_valid;
		end
	end

	assign hog_out0 = mag_q[0];
	assign hog_out1 = mag_q[1];
	assign hog_out2 = mag_q[2];
	assign hog_out3 = mag_q[3];

	// exact sums of the differences entering the squares
	always_comb begin
		mag_over = 1'b0;
		for (int i = 0; i < NPIX; i++) begin
			if (full_square(gx[i * GRAD_W +: GRAD_W]) +
				full_square(gy[i * GRAD_W +: GRAD_W]) > MAG_MAX)
				mag_over = 1'b1;
		end
	end

	// upstream differences must stay within one pixel range
	a_mag_range: assert property (@(posedge clk) disable iff (!rst_n) grad_valid |-> !mag_over)
		else $error("sum of squares above 2*255^2 at stage input");

endmodule

/* rtl/window_assembler.sv */
`timescale 1ns/1ps

module window_assembler
	import hog_pkg::*;
#(
	parameter int FRAME_TILES_X = 53
) (
	input  logic     clk,
	input  logic     rst_n,
	input  row_idx_t tile_row,
	input  col_idx_t tile_col,
	input  block_t   block0,
	input  block_t   block1,
	input  block_t   block2,
	input  block_t   block3,
	output win_t     win,
	output logic     win_valid
);

	// offset of the tile inside the window
	localparam int ROW_OFF = WIN_H - TILE_H;
	localparam int COL_OFF = WIN_W - TILE_W;
	// bottom two window rows go back to the line buffer
	localparam int WR_LSB  = (WIN_H - 2) * WIN_W * PIX_W;

	block_t               blk [TILE_BLK];
	pix_t                 tile_px [TILE_H][TILE_W];
	pix_t                 carry [TILE_H][COL_OFF];
	logic [LINE_BITS-1:0] rd_rows;
	logic                 first_tile;
	logic                 frame_started;

	////////////////////////////////////////
	// blocks to tile pixels
	////////////////////////////////////////
	assign blk[0] = block0;
	assign blk[1] = block1;
	assign blk[2] = block2;
	assign blk[3] = block3;

	always_comb begin
		for (int r = 0; r < TILE_H; r++) begin
			for (int c = 0; c < TILE_W; c++) begin
				// index 8 is top-left, index 0 bottom-right
				tile_px[r][c] = blk[c / BLK_S][
					((BLK_S - 1 - r) * BLK_S + BLK_S - 1 - c % BLK_S) * PIX_W +: PIX_W];
			end
		end
	end

	////////////////////////////////////////
	// window assembly
	////////////////////////////////////////
	always_comb begin
		win = '0;
		// rows above come from the previous band, zero at top edge
		if (tile_row != '0)
			win[0 +: LINE_BITS] = rd_rows;
		for (int r = 0; r < TILE_H; r++) begin
			// left columns from previous tile, zero at left edge
			for (int c = 0; c < COL_OFF; c++) begin
				if (tile_col != '0)
					win[((r + ROW_OFF) * WIN_W + c) * PIX_W +: PIX_W] = carry[r][c];
			end
			for (int c = 0; c < TILE_W; c++) begin
				win[((r + ROW_OFF) * WIN_W + c + COL_OFF) * PIX_W +: PIX_W] = tile_px[r][c];
			end
		end
	end

	// last two tile columns feed the next tile
	always_ff @(posedge clk) begin
		for (int r = 0; r < TILE_H; r++) begin
			for (int c = 0; c < COL_OFF; c++) begin
				carry[r][c] <= tile_px[r][TILE_W - COL_OFF + c];
			end
		end
	end

	band_line_buffer #(
		.FRAME_TILES_X(FRAME_TILES_X)
	) u_line_buf (
		.clk    (clk),
		.col    (tile_col),
		.wr_rows(win[WR_LSB +: LINE_BITS]),
		.rd_rows(rd_rows)
	);

	////////////////////////////////////////
	// frame start tracking
	////////////////////////////////////////
	assign first_tile = (tile_row == '0) && (tile_col == '0);

	always_ff @(posedge clk) begin
		if (!rst_n)
			frame_started <= 1'b0;
		else if (first_tile)
			frame_started <= 1'b1;
	end

	// also high during the very first tile
	assign win_valid = frame_started | first_tile;

endmodule

/* sim.f */
+incdir+test
rtl/hog_pkg.sv
rtl/band_line_buffer.sv
rtl/window_assembler.sv
rtl/gradient_stage.sv
rtl/magnitude_stage.sv
rtl/hog_grad_top.sv
test/tb_hog_grad.sv

/* test/hog_ref_model.svh */
`ifndef HOG_REF_MODEL_SVH
`define HOG_REF_MODEL_SVH

// uses FRAME_W, FRAME_H, the RULE_* codes and seed of the enclosing testbench

// two zero rows above and two zero columns left of the frame
localparam int PAD = 2;

// frame pixel (y, x) lives at [y+PAD][x+PAD]
pix_t pad_px [FRAME_H+PAD][FRAME_W+PAD];

function automatic pix_t frame_pixel(int rule, int param, int y, int x);
	case (rule)
		RULE_CONST: return pix_t'(param);
		RULE_HRAMP: return pix_t'(x);
		RULE_VRAMP: return pix_t'(y);
		default:    return pix_t'($random(seed));
	endcase
endfunction

function automatic void fill_frame(int rule, int param);
	for (int y = 0; y < FRAME_H + PAD; y++)
		for (int x = 0; x < FRAME_W + PAD; x++)
			pad_px[y][x] = '0;
	for (int y = 0; y < FRAME_H; y++)
		for (int x = 0; x < FRAME_W; x++)
			pad_px[y+PAD][x+PAD] = frame_pixel(rule, param, y, x);
endfunction

// anything above or left of the frame reads as zero
function automatic int pix_at(int y, int x);
	return int'(pad_px[y+PAD][x+PAD]);
endfunction

// input block b of tile (tr, tc), top-left pixel at index 8
function automatic block_t tile_block(int tr, int tc, int b);
	block_t blk;
	blk = '0;
	for (int r = 0; r < BLK_S; r++)
		for (int cc = 0; cc < BLK_S; cc++)
			blk[(BLK_N - 1 - (r * BLK_S + cc)) * PIX_W +: PIX_W] =
				pix_t'(pix_at(tr * TILE_H + r, tc * TILE_W + b * BLK_S + cc));
	return blk;
endfunction

// output block b, window shifted one pixel up and one left of the tile
function automatic mag_block_t expected_block(int tr, int tc, int b);
	mag_block_t blk;
	int y;
	int x;
	int gx;
	int gy;
	blk = '0;
	for (int r = 0; r < BLK_S; r++) begin
		for (int cc = 0; cc < BLK_S; cc++) begin
			y = tr * TILE_H + r - 1;
			x = tc * TILE_W + b * BLK_S + cc - 1;
			gx = pix_at(y, x + 1) - pix_at(y, x - 1);
			gy = pix_at(y - 1, x) - pix_at(y + 1, x);
			blk[(BLK_N - 1 - (r * BLK_S + cc)) * MAG_W +: MAG_W] = mag_t'(gx * gx + gy * gy);
		end
	end
	return blk;
endfunction

`endif

/* test/tb_hog_grad.sv */
`timescale 1ns/1ps

module tb_hog_grad
	import hog_pkg::*;
();

	localparam int FRAME_X      = 4;
	localparam int FRAME_Y      = 3;
	localparam int FRAME_W      = FRAME_X * TILE_W;
	localparam int FRAME_H      = FRAME_Y * TILE_H;
	localparam int N_TILES      = FRAME_X * FRAME_Y;
	localparam int N_TESTS      = 6;
	localparam int PIPE_LAT     = 3;
	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 8;
	localparam int WATCHDOG_NS  = (N_TILES * N_TESTS + 50) * CLK_PERIOD;

	localparam int RULE_CONST = 0;
	localparam int RULE_HRAMP = 1;
	localparam int RULE_VRAMP = 2;
	localparam int RULE_RAND  = 3;

	// frame patterns applied back to back
	string test_name [N_TESTS] = '{"const_200", "hramp", "vramp", "random_a",
		"const_255", "random_b"};
	int test_rule [N_TESTS] = '{RULE_CONST, RULE_HRAMP, RULE_VRAMP, RULE_RAND,
		RULE_CONST, RULE_RAND};
	int test_param [N_TESTS] = '{200, 0, 0, 0, 255, 0};

	logic       clk;
	logic       rst_n;
	row_idx_t   tile_row;
	col_idx_t   tile_col;
	block_t     blk_in [TILE_BLK];
	mag_block_t hog_out [TILE_BLK];
	logic       valid;

	int         seed;
	int         edge_cnt = 0;
	int         first_due = 0;
	logic       started = 1'b0;
	int         due_q [$];
	string      tag_q [$];
	mag_block_t blk_q [$];

	`include "hog_ref_model.svh"

	hog_grad_top #(
		.FRAME_TILES_X(FRAME_X),
		.FRAME_TILES_Y(FRAME_Y)
	) dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.tile_row(tile_row),
		.tile_col(tile_col),
		.block0  (blk_in[0]),
		.block1  (blk_in[1]),
		.block2  (blk_in[2]),
		.block3  (blk_in[3]),
		.hog_out0(hog_out[0]),
		.hog_out1(hog_out[1]),
		.hog_out2(hog_out[2]),
		.hog_out3(hog_out[3]),
		.valid   (valid)
	);

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_mag(string name, mag_block_t exp_v, mag_block_t act_v);
		if (act_v !== exp_v) begin
			$display("CHECK FAILED %s: expected %h actual %h", name, exp_v, act_v);
			$display("test failed");
			$fatal(1, "magnitude mismatch");
		end
	endtask

	task automatic check_valid(string name, logic exp_v, logic act_v);
		if (act_v !== exp_v) begin
			$display("CHECK FAILED %s: expected %b actual %b", name, exp_v, act_v);
			$display("test failed");
			$fatal(1, "valid mismatch");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	initial begin
		#(WATCHDOG_NS);
		$display("run hung, outputs still pending after %0d ns", WATCHDOG_NS);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial begin
		int due;
		seed  = 29224;
		rst_n = 1'b0;
		// idle away from tile 0,0 so the frame does not start early
		tile_row = row_idx_t'(FRAME_Y - 1);
		tile_col = col_idx_t'(FRAME_X - 1);
		for (int b = 0; b < TILE_BLK; b++)
			blk_in[b] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		for (int t = 0; t < N_TESTS; t++) begin
			fill_frame(test_rule[t], test_param[t]);
			for (int tr = 0; tr < FRAME_Y; tr++) begin
				for (int tc = 0; tc < FRAME_X; tc++) begin
					@(posedge clk);
					tile_row <= row_idx_t'(tr);
					tile_col <= col_idx_t'(tc);
					for (int b = 0; b < TILE_BLK; b++)
						blk_in[b] <= tile_block(tr, tc, b);
					// seen at the negedge after the third edge from now
					due = edge_cnt + PIPE_LAT + 1;
					if (!started) begin
						started   = 1'b1;
						first_due = due;
					end
					due_q.push_back(due);
					tag_q.push_back($sformatf("%s tile %0d,%0d", test_name[t], tr, tc));
					for (int b = 0; b < TILE_BLK; b++)
						blk_q.push_back(expected_block(tr, tc, b));
				end
			end
		end

		while (due_q.size() != 0)
			@(posedge clk);

		$display("test passed");
		$finish;
	end

	////////////////////////////////////////
	// output monitor
	////////////////////////////////////////
	always @(negedge clk) begin
		string tag;
		if (edge_cnt > 0)
			check_valid($sformatf("valid at edge %0d", edge_cnt),
				started && (edge_cnt >= first_due), valid);
		if (due_q.size() > 0 && due_q[0] == edge_cnt) begin
			tag = tag_q.pop_front();
			void'(due_q.pop_front());
			for (int b = 0; b < TILE_BLK; b++)
				check_mag($sformatf("%s blk%0d", tag, b), blk_q.pop_front(), hog_out[b]);
		end
	end

endmodule
